// File: list.f
source/ccu_line_pkg.sv
source/cache_addr_pkg.sv
source/vq_entry.sv
source/vq_queue_ctrl.sv
source/victim_queue.sv
source/ccu_line_writer.sv
source/vq_top.sv
verif/vq_top_sva.sv
verif/vq_checker.sv
verif/tb_vq_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the victim queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_vq_top --Mdir build -o sim_vq -f list.f

./build/sim_vq | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi

// File: source/cache_addr_pkg.sv
/*
 * Byte address format of the data cache.
 * An address is seen either as one raw word or as line number plus byte offset.
 */
package cache_addr_pkg;

    localparam int ADDR_WIDTH      = 32;
    localparam int OFFSET_WIDTH    = 4;
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;

    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;

    // Same bits, two decodings
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        struct packed {
            line_addr_t              line;
            logic [OFFSET_WIDTH-1:0] offset;
        } fields;
    } byte_addr_u;

endpackage

// File: source/ccu_line_pkg.sv
/*
 * Data word and cacheline geometry for the CCU victim path.
 * Referenced by scoped name from the queue, the line writer and the testbench.
 */
package ccu_line_pkg;

    // Memory word and lookup data
    localparam int DATA_WIDTH = 32;
    localparam int DATA_BYTES = DATA_WIDTH / 8;

    // Cacheline
    localparam int LINE_BYTES = 16;
    localparam int LINE_WIDTH = LINE_BYTES * 8;

    // Word writes needed to send one line to memory
    localparam int WORDS_PER_LINE = LINE_BYTES / DATA_BYTES;

endpackage

// File: source/ccu_line_writer.sv
/*
 * Sends one cacheline to memory as a burst of word writes over valid/ready.
 * Pulses done for one cycle after the last word has been accepted.
 */
`timescale 1ns/100ps

module ccu_line_writer (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,

    input  logic                                  i_ccu_en,
    input  logic [cache_addr_pkg::ADDR_WIDTH-1:0] i_ccu_addr,
    input  logic [ccu_line_pkg::LINE_WIDTH-1:0]   i_ccu_data,
    output logic                                  o_ccu_done,

    output logic                                  o_mem_wr_valid,
    output logic [cache_addr_pkg::ADDR_WIDTH-1:0] o_mem_wr_addr,
    output logic [ccu_line_pkg::DATA_WIDTH-1:0]   o_mem_wr_data,
    input  logic                                  i_mem_wr_ready
);

    localparam int CNT_WIDTH  = $clog2(ccu_line_pkg::WORDS_PER_LINE);
    localparam int BYTE_SHIFT = $clog2(ccu_line_pkg::DATA_BYTES);

    logic                                  busy;
    logic [CNT_WIDTH-1:0]                  word_cnt;
    logic [cache_addr_pkg::ADDR_WIDTH-1:0] base_addr;
    logic [ccu_line_pkg::LINE_WIDTH-1:0]   line_data;
    logic [cache_addr_pkg::ADDR_WIDTH-1:0] word_offset;
    logic                                  last_word;

    assign last_word = (word_cnt == CNT_WIDTH'(ccu_line_pkg::WORDS_PER_LINE - 1));

    // The done cycle still shows the retiring head, so en is not taken then
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy       <= 1'b0;
            word_cnt   <= '0;
            o_ccu_done <= 1'b0;
        end else begin
            o_ccu_done <= 1'b0;
            if (!busy) begin
                if (i_ccu_en && !o_ccu_done) begin
                    busy     <= 1'b1;
                    word_cnt <= '0;
                end
            end else if (i_mem_wr_ready) begin
                word_cnt <= word_cnt + 1'b1;
                if (last_word) begin
                    busy       <= 1'b0;
                    o_ccu_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!busy && i_ccu_en && !o_ccu_done) begin
            base_addr <= i_ccu_addr;
            line_data <= i_ccu_data;
        end
    end

    always_comb begin
        word_offset = '0;
        word_offset[BYTE_SHIFT +: CNT_WIDTH] = word_cnt;
    end

    assign o_mem_wr_valid = busy;
    assign o_mem_wr_addr  = base_addr + word_offset;
    assign o_mem_wr_data  = line_data[word_cnt*ccu_line_pkg::DATA_WIDTH +: ccu_line_pkg::DATA_WIDTH];

endmodule

// File: source/victim_queue.sv
/*
 * Victim queue holding evicted lines until the line writer has stored them.
 * Loads look up by byte address and get the selected bytes one cycle later.
 */
`timescale 1ns/100ps

module victim_queue #(
    parameter  int VQ_DEPTH  = 4,
    localparam int IDX_WIDTH = (VQ_DEPTH > 1) ? $clog2(VQ_DEPTH) : 1
) (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,

    // Victim enqueue
    input  logic                                  i_victim_valid,
    input  logic [cache_addr_pkg::ADDR_WIDTH-1:0] i_victim_addr,
    input  logic [ccu_line_pkg::LINE_WIDTH-1:0]   i_victim_data,

    // Load lookup
    input  logic                                  i_lookup_valid,
    input  logic [cache_addr_pkg::ADDR_WIDTH-1:0] i_lookup_addr,
    input  logic [ccu_line_pkg::DATA_BYTES-1:0]   i_lookup_byte_sel,
    output logic                                  o_lookup_hit,
    output logic [ccu_line_pkg::DATA_WIDTH-1:0]   o_lookup_data,

    output logic                                  o_vq_full,

    // Line writer handshake
    input  logic                                  i_ccu_done,
    output logic                                  o_ccu_en,
    output logic [cache_addr_pkg::ADDR_WIDTH-1:0] o_ccu_addr,
    output logic [ccu_line_pkg::LINE_WIDTH-1:0]   o_ccu_data
);

    cache_addr_pkg::byte_addr_u victim_addr_u;
    cache_addr_pkg::byte_addr_u lookup_addr_u;
    cache_addr_pkg::byte_addr_u head_addr_u;

    logic [IDX_WIDTH-1:0] head;
    logic [IDX_WIDTH-1:0] tail;
    logic                 queue_full;
    logic                 queue_empty;
    logic                 allocating;

    logic [VQ_DEPTH-1:0]                entry_valid;
    logic [VQ_DEPTH-1:0]                entry_hit;
    cache_addr_pkg::line_addr_t         entry_addr [VQ_DEPTH];
    logic [ccu_line_pkg::LINE_WIDTH-1:0] entry_data [VQ_DEPTH];

    logic                                lookup_hit;
    logic [ccu_line_pkg::LINE_WIDTH-1:0] hit_line;
    logic [ccu_line_pkg::DATA_WIDTH-1:0] lookup_word;

    assign victim_addr_u.raw = i_victim_addr;
    assign lookup_addr_u.raw = i_lookup_addr;

    // Lines offered while full are dropped
    assign allocating = i_victim_valid && !queue_full;

    vq_queue_ctrl #(
        .VQ_DEPTH(VQ_DEPTH)
    ) u_queue_ctrl (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_incr_head(i_ccu_done),
        .i_incr_tail(allocating),
        .o_head     (head),
        .o_tail     (tail),
        .o_full     (queue_full),
        .o_empty    (queue_empty)
    );

    for (genvar i = 0; i < VQ_DEPTH; i++) begin : g_entry
        vq_entry u_entry (
            .i_clk        (i_clk),
            .i_rst_n      (i_rst_n),
            .i_alloc_en   (allocating && (tail == IDX_WIDTH'(i))),
            .i_alloc_addr (victim_addr_u.fields.line),
            .i_alloc_data (i_victim_data),
            .i_retire     (i_ccu_done && (head == IDX_WIDTH'(i))),
            .i_lookup_addr(lookup_addr_u.fields.line),
            .o_lookup_hit (entry_hit[i]),
            .o_valid      (entry_valid[i]),
            .o_addr       (entry_addr[i]),
            .o_data       (entry_data[i])
        );
    end

    assign lookup_hit = i_lookup_valid && (entry_hit != '0);

    // First matching slot supplies the line
    always_comb begin
        hit_line = entry_data[0];
        for (int i = VQ_DEPTH - 1; i >= 0; i--) begin
            if (entry_hit[i]) hit_line = entry_data[i];
        end
    end

    // Bytes that would run past the end of the line read as zero
    always_comb begin
        int pos;
        lookup_word = '0;
        for (int j = 0; j < ccu_line_pkg::DATA_BYTES; j++) begin
            pos = int'(lookup_addr_u.fields.offset) + j;
            if (i_lookup_byte_sel[j] && (pos < ccu_line_pkg::LINE_BYTES)) begin
                lookup_word[j*8 +: 8] = hit_line[pos*8 +: 8];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_lookup_hit  <= 1'b0;
            o_lookup_data <= '0;
        end else begin
            o_lookup_hit  <= lookup_hit;
            o_lookup_data <= lookup_hit ? lookup_word : '0;
        end
    end

    // Head entry goes to the writer at its line base address
    assign head_addr_u.fields.line   = entry_addr[head];
    assign head_addr_u.fields.offset = '0;

    assign o_ccu_en   = entry_valid[head] && !queue_empty;
    assign o_ccu_addr = head_addr_u.raw;
    assign o_ccu_data = entry_data[head];
    assign o_vq_full  = queue_full;

endmodule

// File: source/vq_entry.sv
/*
 * One victim queue slot with its line address, line data and valid bit.
 * Compares its stored line number against the lookup address every cycle.
 */
`timescale 1ns/100ps

module vq_entry (
    input  logic                                i_clk,
    input  logic                                i_rst_n,

    input  logic                                i_alloc_en,
    input  cache_addr_pkg::line_addr_t          i_alloc_addr,
    input  logic [ccu_line_pkg::LINE_WIDTH-1:0] i_alloc_data,
    input  logic                                i_retire,

    input  cache_addr_pkg::line_addr_t          i_lookup_addr,
    output logic                                o_lookup_hit,

    output logic                                o_valid,
    output cache_addr_pkg::line_addr_t          o_addr,
    output logic [ccu_line_pkg::LINE_WIDTH-1:0] o_data
);

    // Allocation wins over retirement
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else if (i_alloc_en) begin
            o_valid <= 1'b1;
        end else if (i_retire) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_alloc_en) begin
            o_addr <= i_alloc_addr;
            o_data <= i_alloc_data;
        end
    end

    assign o_lookup_hit = o_valid && (o_addr == i_lookup_addr);

endmodule

// File: source/vq_queue_ctrl.sv
/*
 * Head and tail pointers of a circular queue of any depth.
 * A lap bit on each pointer separates the full case from the empty case.
 */
`timescale 1ns/100ps

module vq_queue_ctrl #(
    parameter  int VQ_DEPTH  = 4,
    localparam int IDX_WIDTH = (VQ_DEPTH > 1) ? $clog2(VQ_DEPTH) : 1
) (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_incr_head,
    input  logic                 i_incr_tail,
    output logic [IDX_WIDTH-1:0] o_head,
    output logic [IDX_WIDTH-1:0] o_tail,
    output logic                 o_full,
    output logic                 o_empty
);

    // Pointer layout is {lap, index}
    logic [IDX_WIDTH:0] head_ptr;
    logic [IDX_WIDTH:0] tail_ptr;

    // Wrap the index at the last slot and flip the lap bit
    function automatic logic [IDX_WIDTH:0] advance(input logic [IDX_WIDTH:0] ptr);
        logic [IDX_WIDTH:0] nxt;
        if (ptr[IDX_WIDTH-1:0] == IDX_WIDTH'(VQ_DEPTH - 1)) begin
            nxt = {~ptr[IDX_WIDTH], {IDX_WIDTH{1'b0}}};
        end else begin
            nxt = ptr + (IDX_WIDTH + 1)'(1);
        end
        return nxt;
    endfunction

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_ptr <= '0;
            tail_ptr <= '0;
        end else begin
            if (i_incr_head) head_ptr <= advance(head_ptr);
            if (i_incr_tail) tail_ptr <= advance(tail_ptr);
        end
    end

    assign o_head  = head_ptr[IDX_WIDTH-1:0];
    assign o_tail  = tail_ptr[IDX_WIDTH-1:0];
    assign o_empty = (head_ptr == tail_ptr);
    assign o_full  = (head_ptr[IDX_WIDTH-1:0] == tail_ptr[IDX_WIDTH-1:0]) &&
                     (head_ptr[IDX_WIDTH] != tail_ptr[IDX_WIDTH]);

endmodule

// File: source/vq_top.sv
/*
 * Victim queue joined to its memory line writer.
 * Evicted lines enter here and leave as word writes on the memory channel.
 */
`timescale 1ns/100ps

module vq_top #(
    parameter int VQ_DEPTH = 4
) (
    input  logic                                  i_clk,
    input  logic                                  i_rst_n,

    input  logic                                  i_victim_valid,
    input  logic [cache_addr_pkg::ADDR_WIDTH-1:0] i_victim_addr,
    input  logic [ccu_line_pkg::LINE_WIDTH-1:0]   i_victim_data,
    output logic                                  o_vq_full,

    input  logic                                  i_lookup_valid,
    input  logic [cache_addr_pkg::ADDR_WIDTH-1:0] i_lookup_addr,
    input  logic [ccu_line_pkg::DATA_BYTES-1:0]   i_lookup_byte_sel,
    output logic                                  o_lookup_hit,
    output logic [ccu_line_pkg::DATA_WIDTH-1:0]   o_lookup_data,

    output logic                                  o_mem_wr_valid,
    output logic [cache_addr_pkg::ADDR_WIDTH-1:0] o_mem_wr_addr,
    output logic [ccu_line_pkg::DATA_WIDTH-1:0]   o_mem_wr_data,
    input  logic                                  i_mem_wr_ready
);

    logic                                  ccu_en;
    logic                                  ccu_done;
    logic [cache_addr_pkg::ADDR_WIDTH-1:0] ccu_addr;
    logic [ccu_line_pkg::LINE_WIDTH-1:0]   ccu_data;

    victim_queue #(
        .VQ_DEPTH(VQ_DEPTH)
    ) u_victim_queue (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_victim_valid   (i_victim_valid),
        .i_victim_addr    (i_victim_addr),
        .i_victim_data    (i_victim_data),
        .i_lookup_valid   (i_lookup_valid),
        .i_lookup_addr    (i_lookup_addr),
        .i_lookup_byte_sel(i_lookup_byte_sel),
        .o_lookup_hit     (o_lookup_hit),
        .o_lookup_data    (o_lookup_data),
        .o_vq_full        (o_vq_full),
        .i_ccu_done       (ccu_done),
        .o_ccu_en         (ccu_en),
        .o_ccu_addr       (ccu_addr),
        .o_ccu_data       (ccu_data)
    );

    ccu_line_writer u_line_writer (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_ccu_en      (ccu_en),
        .i_ccu_addr    (ccu_addr),
        .i_ccu_data    (ccu_data),
        .o_ccu_done    (ccu_done),
        .o_mem_wr_valid(o_mem_wr_valid),
        .o_mem_wr_addr (o_mem_wr_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .i_mem_wr_ready(i_mem_wr_ready)
    );

endmodule

// File: verif/tb_vq_top.sv
/*
 * Testbench for the victim queue top level.
 * Runs a table of enqueue, lookup and memory-ready rows against vq_checker's model.
 */
`timescale 1ns/100ps

module tb_vq_top;

    localparam int VQ_DEPTH = 4;
    localparam int MAX_ROWS = 40;
    localparam int TIMEOUT  = 2000;

    // Row kinds and ready modes
    localparam int OP_ENQ   = 0;
    localparam int OP_LOOK  = 1;
    localparam int OP_MODE  = 2;
    localparam int OP_DRAIN = 3;
    localparam int OP_STEP  = 4;
    localparam int RDY_LOW  = 0;
    localparam int RDY_HIGH = 1;
    localparam int RDY_RAND = 2;
    localparam int RDY_STEP = 3;

    logic         clk;
    logic         rst_n;
    logic         victim_valid;
    logic [31:0]  victim_addr;
    logic [127:0] victim_data;
    logic         vq_full;
    logic         lookup_valid;
    logic [31:0]  lookup_addr;
    logic [3:0]   lookup_sel;
    logic         lookup_hit;
    logic [31:0]  lookup_data;
    logic         mem_valid;
    logic [31:0]  mem_addr;
    logic [31:0]  mem_data;
    logic         mem_ready;
    logic         exp_hit;
    logic [31:0]  exp_data;
    int           ready_mode;
    logic         step_taken;
    int           seed;
    int           errors;
    int           tests;
    int           model_count;

    int           row_op   [MAX_ROWS];
    int           row_arg  [MAX_ROWS];
    logic [31:0]  row_addr [MAX_ROWS];
    logic [127:0] row_data [MAX_ROWS];
    logic [3:0]   row_sel  [MAX_ROWS];
    logic         row_hit  [MAX_ROWS];
    logic [31:0]  row_exp  [MAX_ROWS];
    int           n_rows;

    vq_top #(
        .VQ_DEPTH(VQ_DEPTH)
    ) i_dut (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_victim_valid(victim_valid), .i_victim_addr(victim_addr),
        .i_victim_data(victim_data), .o_vq_full(vq_full),
        .i_lookup_valid(lookup_valid), .i_lookup_addr(lookup_addr),
        .i_lookup_byte_sel(lookup_sel), .o_lookup_hit(lookup_hit),
        .o_lookup_data(lookup_data),
        .o_mem_wr_valid(mem_valid), .o_mem_wr_addr(mem_addr),
        .o_mem_wr_data(mem_data), .i_mem_wr_ready(mem_ready)
    );

    vq_checker #(
        .VQ_DEPTH(VQ_DEPTH)
    ) u_checker (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_victim_valid(victim_valid), .i_victim_addr(victim_addr),
        .i_victim_data(victim_data), .i_vq_full(vq_full),
        .i_lookup_valid(lookup_valid), .i_lookup_addr(lookup_addr),
        .i_lookup_byte_sel(lookup_sel), .i_lookup_hit(lookup_hit),
        .i_lookup_data(lookup_data), .i_exp_hit(exp_hit), .i_exp_data(exp_data),
        .i_mem_wr_valid(mem_valid), .i_mem_wr_addr(mem_addr),
        .i_mem_wr_data(mem_data), .i_mem_wr_ready(mem_ready),
        .o_errors(errors), .o_tests(tests), .o_count(model_count)
    );

    always #5 clk = ~clk;

    // Each line gets distinct bytes so misplaced words show up
    function automatic logic [127:0] make_line(input int n);
        logic [127:0] line;
        for (int b = 0; b < 16; b++) begin
            line[b*8 +: 8] = 8'(n * 16 + b) ^ 8'h5a;
        end
        return line;
    endfunction

    function automatic logic [31:0] line_base(input int n);
        return 32'h0040_0000 + 32'(n * 256);
    endfunction

    // Byte j comes from line byte off+j if selected and still inside the line
    function automatic logic [31:0] select_bytes(input logic [127:0] line, input int off,
                                                 input logic [3:0] sel);
        logic [31:0] word;
        word = '0;
        for (int j = 0; j < 4; j++) begin
            if (sel[j] && (off + j) <= 15) word[j*8 +: 8] = line[(off + j)*8 +: 8];
        end
        return word;
    endfunction

    task automatic add_row(input int op, input int arg, input int off, input logic [3:0] sel,
                           input logic hit);
        row_op[n_rows]   = op;
        row_arg[n_rows]  = arg;
        row_addr[n_rows] = line_base(arg) + 32'(off);
        row_data[n_rows] = make_line(arg);
        row_sel[n_rows]  = sel;
        row_hit[n_rows]  = hit;
        row_exp[n_rows]  = hit ? select_bytes(make_line(arg), off, sel) : 32'h0;
        n_rows++;
    endtask

    task automatic give_up(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_drain();
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (model_count == 0 && !mem_valid) break;
        end
        if (n == TIMEOUT) give_up("the queue to drain");
    endtask

    task automatic release_one_word();
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (step_taken) break;
        end
        if (n == TIMEOUT) begin
            give_up("a single memory word");
        end else begin
            @(posedge clk);
            ready_mode <= RDY_LOW;
        end
    endtask

    // Step mode of memory ready lets exactly one word through
    always @(posedge clk) begin
        if (ready_mode != RDY_STEP) step_taken <= 1'b0;
        else if (mem_valid && mem_ready) step_taken <= 1'b1;
        case (ready_mode)
            RDY_LOW:  mem_ready <= 1'b0;
            RDY_RAND: mem_ready <= $random(seed) & 1;
            RDY_STEP: mem_ready <= !(step_taken || (mem_valid && mem_ready));
            default:  mem_ready <= 1'b1;
        endcase
    end

    initial begin
        clk = 0;
        rst_n = 0;
        victim_valid = 0;
        victim_addr = '0;
        victim_data = '0;
        lookup_valid = 0;
        lookup_addr = '0;
        lookup_sel = '0;
        mem_ready = 0;
        exp_hit = 0;
        exp_data = '0;
        ready_mode = RDY_LOW;
        step_taken = 0;
        seed = 32'h6b114f71;
        n_rows = 0;

        // Ready low, lookups with gaps and end-of-line offsets
        add_row(OP_ENQ, 1, 0, 4'h0, 0);
        add_row(OP_ENQ, 2, 0, 4'h0, 0);
        add_row(OP_LOOK, 1, 0, 4'b1111, 1);
        add_row(OP_LOOK, 1, 5, 4'b1011, 1);
        add_row(OP_LOOK, 2, 13, 4'b1111, 1);
        add_row(OP_LOOK, 2, 15, 4'b1111, 1);
        add_row(OP_LOOK, 2, 14, 4'b0110, 1);
        add_row(OP_LOOK, 9, 4, 4'b1111, 0);
        // Fill up, then offer one line too many
        add_row(OP_ENQ, 3, 0, 4'h0, 0);
        add_row(OP_ENQ, 4, 0, 4'h0, 0);
        add_row(OP_ENQ, 5, 0, 4'h0, 0);
        add_row(OP_LOOK, 5, 0, 4'b1111, 0);
        add_row(OP_LOOK, 4, 2, 4'b1101, 1);
        // Head line stalled mid-writeback
        add_row(OP_STEP, 0, 0, 4'h0, 0);
        add_row(OP_LOOK, 1, 8, 4'b1111, 1);
        add_row(OP_MODE, RDY_RAND, 0, 4'h0, 0);
        add_row(OP_DRAIN, 0, 0, 4'h0, 0);
        add_row(OP_LOOK, 1, 0, 4'b1111, 0);
        add_row(OP_LOOK, 4, 0, 4'b1111, 0);
        add_row(OP_ENQ, 6, 0, 4'h0, 0);
        add_row(OP_ENQ, 7, 0, 4'h0, 0);
        add_row(OP_LOOK, 6, 3, 4'b0001, 1);
        add_row(OP_MODE, RDY_HIGH, 0, 4'h0, 0);
        add_row(OP_DRAIN, 0, 0, 4'h0, 0);

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            victim_valid <= 1'b0;
            lookup_valid <= 1'b0;
            exp_hit      <= 1'b0;
            exp_data     <= '0;
            case (row_op[i])
                OP_ENQ: begin
                    victim_valid <= 1'b1;
                    victim_addr  <= row_addr[i];
                    victim_data  <= row_data[i];
                end
                OP_LOOK: begin
                    lookup_valid <= 1'b1;
                    lookup_addr  <= row_addr[i];
                    lookup_sel   <= row_sel[i];
                    exp_hit      <= row_hit[i];
                    exp_data     <= row_exp[i];
                end
                OP_MODE:  ready_mode <= row_arg[i];
                OP_DRAIN: wait_drain();
                default: begin
                    ready_mode <= RDY_STEP;
                    release_one_word();
                end
            endcase
        end
        @(posedge clk);
        victim_valid <= 1'b0;
        lookup_valid <= 1'b0;
        exp_hit      <= 1'b0;
        exp_data     <= '0;
        repeat (4) @(posedge clk);

        $display("%0d tests, %0d errors, %0d assertion failures", tests, errors,
                 i_dut.u_sva.fail_count);
        if (errors == 0 && tests > 0 && i_dut.u_sva.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verif/vq_checker.sv
/*
 * Watches the victim queue ports, keeps a model of the queued lines and
 * compares lookup results, the full flag and every memory word write.
 */
`timescale 1ns/100ps

module vq_checker #(
    parameter int VQ_DEPTH = 4
) (
    input  logic         i_clk,
    input  logic         i_rst_n,
    input  logic         i_victim_valid,
    input  logic [31:0]  i_victim_addr,
    input  logic [127:0] i_victim_data,
    input  logic         i_vq_full,
    input  logic         i_lookup_valid,
    input  logic [31:0]  i_lookup_addr,
    input  logic [3:0]   i_lookup_byte_sel,
    input  logic         i_lookup_hit,
    input  logic [31:0]  i_lookup_data,
    input  logic         i_exp_hit,
    input  logic [31:0]  i_exp_data,
    input  logic         i_mem_wr_valid,
    input  logic [31:0]  i_mem_wr_addr,
    input  logic [31:0]  i_mem_wr_data,
    input  logic         i_mem_wr_ready,
    output int           o_errors,
    output int           o_tests,
    output int           o_count
);

    logic [31:0]  q_addr [$];
    logic [127:0] q_data [$];
    int           wcnt = 0;
    logic         pop_next = 0;
    logic         pend_valid = 0;
    logic         pend_hit = 0;
    logic [31:0]  pend_data = '0;
    logic         pend_tab_hit = 0;
    logic [31:0]  pend_tab_data = '0;
    logic [31:0]  pend_addr = '0;

    initial begin
        o_errors = 0;
        o_tests  = 0;
        o_count  = 0;
    end

    function automatic logic [31:0] extract(input logic [127:0] line, input int off,
                                            input logic [3:0] sel);
        logic [31:0] word;
        word = '0;
        for (int j = 0; j < 4; j++) begin
            if (sel[j] && (off + j) < 16) word[j*8 +: 8] = line[(off + j)*8 +: 8];
        end
        return word;
    endfunction

    task automatic report_error(input string msg);
        o_errors++;
        $display("error %0t: %s", $time, msg);
    endtask

    always @(posedge i_clk) begin
        logic        hit;
        logic [31:0] data;
        logic [31:0] want_addr;
        logic [31:0] want_data;
        if (i_rst_n) begin
            // Result of the lookup issued one cycle back, or zero if none
            if (i_lookup_hit !== pend_hit || i_lookup_data !== pend_data) begin
                report_error($sformatf("lookup %08h got hit %0b data %08h, expected %0b %08h",
                             pend_addr, i_lookup_hit, i_lookup_data, pend_hit, pend_data));
            end
            if (pend_valid) begin
                if (pend_hit !== pend_tab_hit || pend_data !== pend_tab_data) begin
                    report_error($sformatf("lookup %08h table expects %0b %08h", pend_addr,
                                 pend_tab_hit, pend_tab_data));
                end
                o_tests++;
                $display("lookup %08h done, hit %0b data %08h", pend_addr, i_lookup_hit,
                         i_lookup_data);
            end

            hit  = 1'b0;
            data = '0;
            if (i_lookup_valid) begin
                for (int i = 0; i < q_addr.size(); i++) begin
                    if (q_addr[i][31:4] == i_lookup_addr[31:4]) begin
                        hit  = 1'b1;
                        data = extract(q_data[i], int'(i_lookup_addr[3:0]), i_lookup_byte_sel);
                    end
                end
            end
            pend_valid    = i_lookup_valid;
            pend_hit      = hit;
            pend_data     = data;
            pend_tab_hit  = i_exp_hit;
            pend_tab_data = i_exp_data;
            pend_addr     = i_lookup_addr;

            if (i_vq_full !== (q_addr.size() == VQ_DEPTH)) begin
                report_error($sformatf("full flag %0b with %0d lines queued", i_vq_full,
                             q_addr.size()));
            end

            // Head frees on the done cycle that follows the last word
            if (pop_next) begin
                void'(q_addr.pop_front());
                void'(q_data.pop_front());
                pop_next = 1'b0;
            end

            if (i_mem_wr_valid && q_addr.size() == 0) begin
                report_error("memory write valid with no line queued");
            end else if (i_mem_wr_valid && i_mem_wr_ready) begin
                want_addr = q_addr[0] + 32'(wcnt * 4);
                want_data = q_data[0][wcnt*32 +: 32];
                if (i_mem_wr_addr !== want_addr || i_mem_wr_data !== want_data) begin
                    report_error($sformatf("memory write %08h/%08h, expected %08h/%08h",
                                 i_mem_wr_addr, i_mem_wr_data, want_addr, want_data));
                end
                wcnt++;
                if (wcnt == 4) begin
                    wcnt     = 0;
                    pop_next = 1'b1;
                    o_tests++;
                    $display("line %08h written back", q_addr[0]);
                end
            end

            if (i_victim_valid && !i_vq_full) begin
                q_addr.push_back({i_victim_addr[31:4], 4'h0});
                q_data.push_back(i_victim_data);
            end
            o_count = q_addr.size();
        end
    end

endmodule

// File: verif/vq_top_sva.sv
/*
 * Concurrent assertions on the memory channel and the queue status.
 * Bound into vq_top, where it also sees the line writer's done pulse.
 */
`timescale 1ns/100ps

module vq_top_sva (
    input logic        i_clk,
    input logic        i_rst_n,
    input logic        o_vq_full,
    input logic        i_ccu_done,
    input logic        o_mem_wr_valid,
    input logic [31:0] o_mem_wr_addr,
    input logic [31:0] o_mem_wr_data,
    input logic        i_mem_wr_ready
);

    int fail_count = 0;

    // A stalled word keeps valid, address and data until accepted
    hold_word: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_mem_wr_valid && !i_mem_wr_ready |=>
            o_mem_wr_valid && $stable(o_mem_wr_addr) && $stable(o_mem_wr_data))
        else begin
            fail_count++;
            $error("memory word changed before ready");
        end

    quiet_in_reset: assert property (@(posedge i_clk)
        !i_rst_n |-> !o_mem_wr_valid && !o_vq_full)
        else begin
            fail_count++;
            $error("status outputs active in reset");
        end

    // With no line retiring, a full queue stays full whatever the source offers
    no_alloc_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_vq_full && !i_ccu_done |=> o_vq_full)
        else begin
            fail_count++;
            $error("line accepted while queue full");
        end

endmodule

bind vq_top vq_top_sva u_sva (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .o_vq_full     (o_vq_full),
    .i_ccu_done    (ccu_done),
    .o_mem_wr_valid(o_mem_wr_valid),
    .o_mem_wr_addr (o_mem_wr_addr),
    .o_mem_wr_data (o_mem_wr_data),
    .i_mem_wr_ready(i_mem_wr_ready)
);
